// File: Bender.yml
package:
  name: lpif_adapter

sources:
  # Packages first, then the RTL bottom-up
  - logic/lpif_pkg.sv
  - logic/phy_pkg.sv
  - logic/lpif_lsm.sv
  - logic/lpif_tx.sv
  - logic/lpif_rx.sv
  - logic/lpif_adapter.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_lpif_adapter.sv

// File: compile.f
+incdir+tests
logic/lpif_pkg.sv
logic/phy_pkg.sv
logic/lpif_lsm.sv
logic/lpif_tx.sv
logic/lpif_rx.sv
logic/lpif_adapter.sv
tests/tb_lpif_adapter.sv

// File: logic/lpif_adapter.sv
// LPIF link-layer to PHY adapter, single lclk domain
// One 32-bit flit per cycle framed into one lane word
// lpbk_en must stay static while traffic is running
// In loopback a flit handshake at N shows on pl_valid at N+2

`timescale 1ns/100ps

module lpif_adapter (
  input  logic                                 lclk,
  input  logic                                 rst,

  // Link layer
  input  logic                                 lp_irdy,
  input  logic [lpif_pkg::LPIF_DATA_WIDTH-1:0] lp_data,
  input  logic [7:0]                           lp_stream,
  input  lpif_pkg::lpif_state_t                lp_state_req,
  input  logic                                 lp_stallack,
  input  logic                                 lp_linkerror,
  output logic                                 pl_trdy,
  output logic                                 pl_valid,
  output logic [lpif_pkg::LPIF_DATA_WIDTH-1:0] pl_data,
  output logic [7:0]                           pl_stream,
  output logic                                 pl_error,
  output lpif_pkg::lpif_state_t                pl_state_sts,
  output logic                                 pl_stallreq,

  // PHY lane
  output logic                                 phy_tx_valid,
  output phy_pkg::lane_word_t                  phy_tx_word,
  input  logic                                 phy_rx_valid,
  input  phy_pkg::lane_word_t                  phy_rx_word,
  input  logic                                 phy_credit_return,
  input  logic                                 lpbk_en
);

  import lpif_pkg::*;

  logic        msg_req;
  lpif_state_t msg_state;
  logic        link_active;
  logic        credit_in;
  logic        rx_state_vld;
  lpif_state_t rx_state;

  //////////////////////////////////////////////////////////////////////
  // Link state machine
  //////////////////////////////////////////////////////////////////////

  lpif_lsm lpif_lsm_i (
    .lclk         (lclk),
    .rst          (rst),
    .lp_state_req (lp_state_req),
    .lp_stallack  (lp_stallack),
    .lp_linkerror (lp_linkerror),
    .rx_state_vld (rx_state_vld),
    .rx_state     (rx_state),
    .msg_req      (msg_req),
    .msg_state    (msg_state),
    .link_active  (link_active),
    .pl_stallreq  (pl_stallreq),
    .pl_state_sts (pl_state_sts)
  );

  // Downstream framing
  lpif_tx lpif_tx_i (
    .lclk         (lclk),
    .rst          (rst),
    .link_active  (link_active),
    .lp_irdy      (lp_irdy),
    .lp_data      (lp_data),
    .lp_stream    (lp_stream),
    .msg_req      (msg_req),
    .msg_state    (msg_state),
    .credit_in    (credit_in),
    .pl_trdy      (pl_trdy),
    .phy_tx_valid (phy_tx_valid),
    .phy_tx_word  (phy_tx_word)
  );

  // Upstream deframing, loopback tap on the tx lane
  lpif_rx lpif_rx_i (
    .lclk              (lclk),
    .rst               (rst),
    .lpbk_en           (lpbk_en),
    .tx_valid          (phy_tx_valid),
    .tx_word           (phy_tx_word),
    .phy_rx_valid      (phy_rx_valid),
    .phy_rx_word       (phy_rx_word),
    .phy_credit_return (phy_credit_return),
    .credit_in         (credit_in),
    .pl_valid          (pl_valid),
    .pl_error          (pl_error),
    .pl_data           (pl_data),
    .pl_stream         (pl_stream),
    .rx_state_vld      (rx_state_vld),
    .rx_state          (rx_state)
  );

endmodule

// File: logic/lpif_lsm.sv
// Link state machine for the LPIF adapter
// Moves RESET -> ACTIVE -> L1 by exchanging state messages over the lane
// A transition completes only after the partner echoes the same state
// In loopback the partner is this adapter, so its own message closes it
// lp_linkerror wins over every other input and is seen one cycle later
// Only a RESET request leaves L1 or LINKERROR

`timescale 1ns/100ps

module lpif_lsm (
  input  logic                  lclk,
  input  logic                  rst,
  input  lpif_pkg::lpif_state_t lp_state_req,
  input  logic                  lp_stallack,
  input  logic                  lp_linkerror,
  input  logic                  rx_state_vld,
  input  lpif_pkg::lpif_state_t rx_state,
  output logic                  msg_req,
  output lpif_pkg::lpif_state_t msg_state,
  output logic                  link_active,
  output logic                  pl_stallreq,
  output lpif_pkg::lpif_state_t pl_state_sts
);

  import lpif_pkg::*;

  lpif_state_t state_q;
  lpif_state_t peer_q;  // Last state message from the partner
  logic        sent_q;  // Our message for the next state is out

  assign pl_state_sts = state_q;
  assign link_active  = (state_q == ACTIVE);

  //////////////////////////////////////////////////////////////////////
  // State register and message requests
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge lclk)
  begin
    msg_req <= 1'b0;  // Single-cycle pulse
    if (rst)
    begin
      state_q     <= RESET;
      peer_q      <= RESET;
      sent_q      <= 1'b0;
      pl_stallreq <= 1'b0;
    end
    else if (lp_linkerror)
    begin
      state_q     <= LINKERROR;
      sent_q      <= 1'b0;
      pl_stallreq <= 1'b0;
    end
    else
    begin
      if (rx_state_vld)
        peer_q <= rx_state;

      case (state_q)
        RESET:
        begin
          if (lp_state_req == ACTIVE && !sent_q)
          begin
            msg_req   <= 1'b1;
            msg_state <= ACTIVE;
            sent_q    <= 1'b1;
          end
          else if (sent_q && peer_q == ACTIVE)
          begin
            state_q <= ACTIVE;
            sent_q  <= 1'b0;
          end
        end

        ACTIVE:
        begin
          // Stall handshake first, then the L1 message
          if (pl_stallreq)
          begin
            if (lp_stallack)
            begin
              pl_stallreq <= 1'b0;
              msg_req     <= 1'b1;
              msg_state   <= L1;
              sent_q      <= 1'b1;
            end
          end
          else if (!sent_q && lp_state_req == L1)
            pl_stallreq <= 1'b1;
          else if (sent_q && peer_q == L1)
          begin
            state_q <= L1;
            sent_q  <= 1'b0;
          end
        end

        L1, LINKERROR:
        begin
          if (lp_state_req == RESET)
          begin
            state_q <= RESET;
            peer_q  <= RESET;  // Forget the old handshake
            sent_q  <= 1'b0;
          end
        end

        default: state_q <= LINKERROR;  // Illegal code
      endcase
    end
  end

  // Stall request is held until the link layer acknowledges it
  stallreq_held: assert property (
    @(posedge lclk) disable iff (rst)
    pl_stallreq && !lp_stallack && !lp_linkerror |=> pl_stallreq
  );

endmodule

// File: logic/lpif_pkg.sv
// Link-layer side definitions for the single-clock LPIF adapter
// One flit of LPIF_DATA_WIDTH bits per lclk cycle, no valid lanes
// Stream ids outside the three below are rejected on the upstream path
// State codes match the values seen on pl_state_sts

package lpif_pkg;

  //////////////////////////////////////////////////////////////////////
  // Flit geometry
  //////////////////////////////////////////////////////////////////////

  localparam int LPIF_DATA_WIDTH = 32;

  //////////////////////////////////////////////////////////////////////
  // Stream ids
  //////////////////////////////////////////////////////////////////////

  localparam logic [7:0] STREAM_MEM_CACHE = 8'h01;  // CXL.mem / CXL.cache
  localparam logic [7:0] STREAM_IO        = 8'h02;  // CXL.io
  localparam logic [7:0] STREAM_ARB_MUX   = 8'h03;  // ARB/MUX control

  //////////////////////////////////////////////////////////////////////
  // Link states
  //////////////////////////////////////////////////////////////////////

  // Subset of the LPIF state encodings
  typedef enum logic [3:0] {
    RESET     = 4'b0000,
    ACTIVE    = 4'b0001,
    L1        = 4'b0100,
    LINKERROR = 4'b1010
  } lpif_state_t;

endpackage

// File: logic/lpif_rx.sv
// Upstream deframing for the LPIF adapter
// lpbk_en picks the local tx lane instead of the PHY receive lane
// DATA words with an unknown stream id raise pl_error and are dropped
// There is no back-pressure, every word is consumed on arrival
// Lane word at cycle M gives pl_valid, pl_error or rx_state_vld at M+1

`timescale 1ns/100ps

module lpif_rx (
  input  logic                                 lclk,
  input  logic                                 rst,
  input  logic                                 lpbk_en,
  input  logic                                 tx_valid,
  input  phy_pkg::lane_word_t                  tx_word,
  input  logic                                 phy_rx_valid,
  input  phy_pkg::lane_word_t                  phy_rx_word,
  input  logic                                 phy_credit_return,
  output logic                                 credit_in,
  output logic                                 pl_valid,
  output logic                                 pl_error,
  output logic [lpif_pkg::LPIF_DATA_WIDTH-1:0] pl_data,
  output logic [7:0]                           pl_stream,
  output logic                                 rx_state_vld,
  output lpif_pkg::lpif_state_t                rx_state
);

  import lpif_pkg::*;
  import phy_pkg::*;

  logic       in_vld;
  lane_word_t in_word;
  logic       is_data;
  logic       is_state;
  logic       legal_id;
  logic       consumed_q;  // Loopback credit, one per word

  // Lane select
  assign in_vld  = lpbk_en ? tx_valid : phy_rx_valid;
  assign in_word = lpbk_en ? tx_word  : phy_rx_word;

  assign is_data  = in_vld && (in_word.kind == DATA);
  assign is_state = in_vld && (in_word.kind == STATE);

  always_comb
  begin
    case (in_word.payload.flit.stream)
      STREAM_MEM_CACHE, STREAM_IO, STREAM_ARB_MUX: legal_id = 1'b1;
      default:                                     legal_id = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge lclk)
  begin
    if (rst)
    begin
      pl_valid     <= 1'b0;
      pl_error     <= 1'b0;
      rx_state_vld <= 1'b0;
      consumed_q   <= 1'b0;
    end
    else
    begin
      pl_valid     <= is_data && legal_id;
      pl_error     <= is_data && !legal_id;  // One-cycle pulse
      rx_state_vld <= is_state;
      consumed_q   <= in_vld;
    end
  end

  always_ff @(posedge lclk)
  begin
    if (is_data && legal_id)
    begin
      pl_data   <= in_word.payload.flit.data;
      pl_stream <= in_word.payload.flit.stream;
    end
    if (is_state)
      rx_state <= lpif_state_t'(in_word.payload.msg.code);
  end

  assign credit_in = lpbk_en ? consumed_q : phy_credit_return;

  valid_xor_error: assert property (
    @(posedge lclk) disable iff (rst) !(pl_valid && pl_error)
  );

endmodule

// File: logic/lpif_tx.sv
// Downstream framing for the LPIF adapter
// Turns accepted flits and state messages into one registered lane word
// A pending state message blocks new flits until it has been sent
// Every lane word spends one credit, credit_in returns one
// Starts with TX_CREDITS after reset and never sends at zero credits
// Handshake or message send at cycle N shows on phy_tx_* at N+1

`timescale 1ns/100ps

module lpif_tx (
  input  logic                                 lclk,
  input  logic                                 rst,
  input  logic                                 link_active,
  input  logic                                 lp_irdy,
  input  logic [lpif_pkg::LPIF_DATA_WIDTH-1:0] lp_data,
  input  logic [7:0]                           lp_stream,
  input  logic                                 msg_req,
  input  lpif_pkg::lpif_state_t                msg_state,
  input  logic                                 credit_in,
  output logic                                 pl_trdy,
  output logic                                 phy_tx_valid,
  output phy_pkg::lane_word_t                  phy_tx_word
);

  import lpif_pkg::*;
  import phy_pkg::*;

  logic                msg_pend_q;
  lpif_state_t         msg_q;
  logic [CREDIT_W-1:0] credit_q;
  logic                has_credit;
  logic                data_go;
  logic                msg_go;
  logic                send;

  assign has_credit = (credit_q != '0);

  // Registered terms only
  assign pl_trdy = link_active && has_credit && !msg_pend_q;

  assign msg_go  = msg_pend_q && has_credit;  // Message first
  assign data_go = lp_irdy && pl_trdy;
  assign send    = msg_go || data_go;

  //////////////////////////////////////////////////////////////////////
  // Pending message and credits
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge lclk)
  begin
    if (rst)
      msg_pend_q <= 1'b0;
    else if (msg_req)
      msg_pend_q <= 1'b1;
    else if (msg_go)
      msg_pend_q <= 1'b0;
  end

  always_ff @(posedge lclk)
  begin
    if (msg_req)
      msg_q <= msg_state;
  end

  always_ff @(posedge lclk)
  begin
    if (rst)
      credit_q <= TX_CREDITS;
    else
    begin
      case ({send, credit_in})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;  // Both or neither
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lane word register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge lclk)
  begin
    if (rst)
    begin
      phy_tx_valid     <= 1'b0;
      phy_tx_word.kind <= NONE;
    end
    else
    begin
      phy_tx_valid     <= send;
      phy_tx_word.kind <= msg_go ? STATE : (data_go ? DATA : NONE);
    end
  end

  always_ff @(posedge lclk)
  begin
    if (msg_go)
    begin
      phy_tx_word.payload.msg.code <= msg_q;
      phy_tx_word.payload.msg.fill <= '0;
    end
    else if (data_go)
    begin
      phy_tx_word.payload.flit.stream <= lp_stream;
      phy_tx_word.payload.flit.data   <= lp_data;
    end
  end

  credit_bound: assert property (
    @(posedge lclk) disable iff (rst) credit_q <= TX_CREDITS
  );

  // A word on the lane was paid for in the cycle before
  no_send_at_zero: assert property (
    @(posedge lclk) disable iff (rst) phy_tx_valid |-> $past(credit_q) != '0
  );

endmodule

// File: logic/phy_pkg.sv
// PHY lane word definitions
// One lane word carries either a data flit or a link state message
// The payload is a packed union, so both views must keep the same width
// Credits count lane words, not bytes

package phy_pkg;

  //////////////////////////////////////////////////////////////////////
  // Flow control
  //////////////////////////////////////////////////////////////////////

  localparam int                  CREDIT_W   = 3;
  localparam logic [CREDIT_W-1:0] TX_CREDITS = 3'd4;  // Receiver buffer depth

  //////////////////////////////////////////////////////////////////////
  // Lane word layout
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    NONE  = 2'd0,  // Idle lane
    DATA  = 2'd1,
    STATE = 2'd2
  } lane_kind_t;

  typedef struct packed {
    logic [7:0]                           stream;
    logic [lpif_pkg::LPIF_DATA_WIDTH-1:0] data;
  } data_view_t;

  // Fill pads the 4-bit code up to the flit view width
  typedef struct packed {
    logic [3:0]                           code;
    logic [lpif_pkg::LPIF_DATA_WIDTH+3:0] fill;
  } state_view_t;

  typedef union packed {
    data_view_t  flit;
    state_view_t msg;
  } lane_payload_u;

  typedef struct packed {
    lane_kind_t    kind;
    lane_payload_u payload;
  } lane_word_t;

endpackage

// File: tests/lpif_tb_util.svh
// Helpers for the LPIF adapter testbench, included inside the TB module
// Needs pl_state_sts declared before the include
// Random bits come from a 32-bit Galois LFSR, one step per bit taken
// Model queues hold accepted flits in order with the cycle they are due

`ifndef LPIF_TB_UTIL_SVH
`define LPIF_TB_UTIL_SVH

localparam logic [31:0] LFSR_SEED = 32'hab21_5087;
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

logic [31:0] lfsr_q = LFSR_SEED;

// Reference model, one entry per accepted legal flit
logic [7:0]  exp_stream[$];
logic [31:0] exp_data[$];
int          exp_cyc[$];
int          err_cyc[$];  // Due cycle of each pl_error pulse

int mismatch_cnt = 0;
int failure_cnt  = 0;

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++)
  begin
    r      = {r[30:0], lfsr_q[0]};
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
  end
  return r;
endfunction

// Ids 1 to 3 are the only legal streams
function automatic logic legal_stream(input logic [7:0] s);
  return (s == lpif_pkg::STREAM_MEM_CACHE) || (s == lpif_pkg::STREAM_IO) ||
         (s == lpif_pkg::STREAM_ARB_MUX);
endfunction

function automatic logic [7:0] pick_stream(input logic bad);
  logic [7:0] s;
  if (bad)
  begin
    s = 8'(rand_bits(8));
    if (legal_stream(s))
      s = s ^ 8'h80;  // Push it out of the legal range
  end
  else
  begin
    s = 8'(rand_bits(2));
    if (s == 8'd0)
      s = lpif_pkg::STREAM_IO;
  end
  return s;
endfunction

task automatic push_flit(input logic [7:0] s, input logic [31:0] d, input int due);
  if (legal_stream(s))
  begin
    exp_stream.push_back(s);
    exp_data.push_back(d);
    exp_cyc.push_back(due);
  end
  else
    err_cyc.push_back(due);
endtask

task automatic drop_flit();
  void'(exp_stream.pop_front());
  void'(exp_data.pop_front());
  void'(exp_cyc.pop_front());
endtask

task automatic report_mismatch(input string msg);
  $display("MISMATCH at %0t: %s", $time, msg);
  mismatch_cnt++;
endtask

task automatic report_failure(input string msg);
  $display("ERROR at %0t: %s", $time, msg);
  failure_cnt++;
endtask

task automatic expect_state(input lpif_pkg::lpif_state_t exp);
  if (pl_state_sts !== exp)
    report_mismatch($sformatf("pl_state_sts is %s, expected %s",
                              pl_state_sts.name(), exp.name()));
endtask

`endif

// File: tests/tb_lpif_adapter.sv
// Testbench for the LPIF adapter in a single lclk domain
// Inputs change on the falling edge and outputs are checked there too
// The PHY partner is modeled by echoing phy_tx back into phy_rx
// Credits are returned per echoed word only when echo_credits is set

`timescale 1ns/100ps

module tb_lpif_adapter;

  import lpif_pkg::*;
  import phy_pkg::*;

  localparam int LPBK_SLOTS  = 200;
  localparam int STALL_SLOTS = 16;
  localparam int EXT_SLOTS   = 100;
  localparam int NUM_FLITS   = LPBK_SLOTS + STALL_SLOTS + EXT_SLOTS;
  localparam int WATCHDOG_NS = (NUM_FLITS + 200) * 10;

  logic                       lclk = 1'b0;
  logic                       rst;
  logic                       lp_irdy;
  logic [LPIF_DATA_WIDTH-1:0] lp_data;
  logic [7:0]                 lp_stream;
  lpif_state_t                lp_state_req;
  logic                       lp_stallack;
  logic                       lp_linkerror;
  logic                       pl_trdy;
  logic                       pl_valid;
  logic [LPIF_DATA_WIDTH-1:0] pl_data;
  logic [7:0]                 pl_stream;
  logic                       pl_error;
  lpif_state_t                pl_state_sts;
  logic                       pl_stallreq;
  logic                       phy_tx_valid;
  lane_word_t                 phy_tx_word;
  logic                       phy_rx_valid;
  lane_word_t                 phy_rx_word;
  logic                       phy_credit_return;
  logic                       lpbk_en;

  int   cyc = 0;  // Falling edges seen
  logic holding = 1'b0;  // Offered flit not yet taken
  logic echo_credits;
  int   credits_owed;
  int   hs_cnt;
  int   tx_data_cnt;
  int   flits_checked = 0;

  `include "lpif_tb_util.svh"

  always #5 lclk = ~lclk;

  lpif_adapter i_lpif_adapter (
    .lclk              (lclk),
    .rst               (rst),
    .lp_irdy           (lp_irdy),
    .lp_data           (lp_data),
    .lp_stream         (lp_stream),
    .lp_state_req      (lp_state_req),
    .lp_stallack       (lp_stallack),
    .lp_linkerror      (lp_linkerror),
    .pl_trdy           (pl_trdy),
    .pl_valid          (pl_valid),
    .pl_data           (pl_data),
    .pl_stream         (pl_stream),
    .pl_error          (pl_error),
    .pl_state_sts      (pl_state_sts),
    .pl_stallreq       (pl_stallreq),
    .phy_tx_valid      (phy_tx_valid),
    .phy_tx_word       (phy_tx_word),
    .phy_rx_valid      (phy_rx_valid),
    .phy_rx_word       (phy_rx_word),
    .phy_credit_return (phy_credit_return),
    .lpbk_en           (lpbk_en)
  );

  //////////////////////////////////////////////////////////////////////
  // Upstream checks and PHY partner
  //////////////////////////////////////////////////////////////////////

  task automatic check_upstream();
    if (pl_valid)
    begin
      if (exp_cyc.size() == 0)
        report_mismatch("pl_valid with no flit in the model");
      else
      begin
        if (pl_stream !== exp_stream[0] || pl_data !== exp_data[0] || cyc != exp_cyc[0])
          report_mismatch($sformatf("got %h/%h at cycle %0d, expected %h/%h at cycle %0d",
                                    pl_stream, pl_data, cyc,
                                    exp_stream[0], exp_data[0], exp_cyc[0]));
        drop_flit();
        flits_checked++;
      end
    end
    else if (exp_cyc.size() != 0 && exp_cyc[0] <= cyc)
    begin
      report_mismatch($sformatf("flit due at cycle %0d never showed", exp_cyc[0]));
      drop_flit();
    end
    if (pl_error)
    begin
      if (err_cyc.size() == 0 || err_cyc[0] != cyc)
        report_mismatch("unexpected pl_error pulse");
      if (err_cyc.size() != 0)
        void'(err_cyc.pop_front());
    end
    else if (err_cyc.size() != 0 && err_cyc[0] <= cyc)
    begin
      report_mismatch("illegal stream id gave no pl_error");
      void'(err_cyc.pop_front());
    end
  endtask

  task automatic cycle();
    @(negedge lclk);
    cyc++;
    check_upstream();
    if (phy_tx_valid && phy_tx_word.kind == DATA)
      tx_data_cnt++;
    phy_rx_valid = phy_tx_valid;  // Echo the lane back
    phy_rx_word  = phy_tx_word;
    if (echo_credits && phy_tx_valid)
      phy_credit_return = 1'b1;
    else if (credits_owed > 0)
    begin
      phy_credit_return = 1'b1;
      credits_owed--;
    end
    else
      phy_credit_return = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Link-layer stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive_slot(input int slot, input bit bad_ok, input bit greedy);
    logic bad;
    bad = bad_ok && (slot % 25 == 7);  // Forced illegal id now and then
    if (!holding)
    begin
      lp_irdy   = greedy || bad || (rand_bits(2) != 0);
      lp_stream = pick_stream(bad);
      lp_data   = rand_bits(32);
    end
    if (lp_irdy && pl_trdy)
    begin
      push_flit(lp_stream, lp_data, cyc + 2);  // Two cycles to pl_valid
      hs_cnt++;
    end
    holding = lp_irdy && !pl_trdy;
    cycle();
  endtask

  task automatic run_traffic(input int slots, input bit bad_ok);
    for (int i = 0; i < slots; i++)
      drive_slot(i, bad_ok, 1'b0);
    while (holding)
      drive_slot(0, 1'b0, 1'b0);
    lp_irdy = 1'b0;
  endtask

  task automatic drain();
    lp_irdy = 1'b0;
    repeat (6) cycle();
    if (phy_tx_valid !== 1'b0)
      report_failure("lane word sent while the link layer was idle");
  endtask

  task automatic wait_state(input lpif_state_t s);
    while (pl_state_sts !== s)
      cycle();
  endtask

  initial
  begin
    rst               = 1'b1;
    lp_irdy           = 1'b0;
    lp_data           = '0;
    lp_stream         = '0;
    lp_state_req      = RESET;
    lp_stallack       = 1'b0;
    lp_linkerror      = 1'b0;
    phy_rx_valid      = 1'b0;
    phy_rx_word       = '0;
    phy_credit_return = 1'b0;
    lpbk_en           = 1'b1;
    echo_credits      = 1'b0;
    credits_owed      = 0;
    hs_cnt            = 0;
    tx_data_cnt       = 0;
    cycle();
    cycle();
    expect_state(RESET);
    if ({pl_trdy, pl_valid, pl_error, pl_stallreq, phy_tx_valid} !== 5'b0)
      report_mismatch("control outputs not all low after reset");
    rst = 1'b0;

    // Bring-up and traffic over loopback
    lp_state_req = ACTIVE;
    wait_state(ACTIVE);
    drain();
    if (pl_trdy !== 1'b1)
      report_mismatch("pl_trdy low on an idle ACTIVE link");
    run_traffic(LPBK_SLOTS, 1'b1);
    drain();

    // External lane with credits withheld
    lpbk_en     = 1'b0;
    cycle();
    hs_cnt      = 0;
    tx_data_cnt = 0;
    for (int i = 0; i < STALL_SLOTS; i++)
      drive_slot(i, 1'b0, 1'b1);
    if (hs_cnt != TX_CREDITS || tx_data_cnt != TX_CREDITS)
      report_mismatch($sformatf("%0d flits taken, %0d words sent, expected %0d of each",
                                hs_cnt, tx_data_cnt, TX_CREDITS));
    if (pl_trdy !== 1'b0)
      report_mismatch("pl_trdy high with no credits left");
    credits_owed = TX_CREDITS;
    echo_credits = 1'b1;
    run_traffic(EXT_SLOTS, 1'b1);
    if (hs_cnt <= TX_CREDITS)
      report_mismatch("traffic did not resume after the credit return");
    drain();

    // L1 entry through the stall handshake
    lp_state_req = L1;
    while (pl_stallreq !== 1'b1)
      cycle();
    repeat (3)
    begin
      cycle();
      if (pl_stallreq !== 1'b1)
        report_mismatch("pl_stallreq dropped before lp_stallack");
    end
    lp_stallack = 1'b1;
    cycle();
    lp_stallack = 1'b0;
    if (pl_stallreq !== 1'b0)
      report_mismatch("pl_stallreq still high after lp_stallack");
    wait_state(L1);
    if (pl_trdy !== 1'b0)
      report_mismatch("pl_trdy high in L1");

    lp_linkerror = 1'b1;
    cycle();
    lp_linkerror = 1'b0;
    expect_state(LINKERROR);
    lp_state_req = RESET;
    cycle();
    expect_state(RESET);
    drain();

    $display("Checks done: %0d flits checked, %0d mismatches, %0d other errors",
             flits_checked, mismatch_cnt, failure_cnt);
    if (mismatch_cnt == 0 && failure_cnt == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d cycles, a wait never ended", cyc);
    $display("Simulation failed");
    $finish;
  end

endmodule
